/* logic/clint.sv */
// Core-local interruptor with mtime, mtimecmp and msip
`timescale 1ns/1ps
`include "machine_trap_params.svh"

module clint (
	input  logic             clk,
	input  logic             rst,
	input  logic             clint_wr_en,
	input  logic [15:0]      clint_addr,
	input  logic [`XLEN-1:0] clint_wdata,
	output logic             msip,
	output logic             mtip,
	output logic [`XLEN-1:0] mtime
);

	logic [`XLEN-1:0] mtimecmp;
	logic             sel_msip;
	logic             sel_mtimecmp;
	logic             sel_mtime;

	assign sel_msip     = clint_wr_en && (clint_addr == `CLINT_MSIP_OFS);
	assign sel_mtimecmp = clint_wr_en && (clint_addr == `CLINT_MTIMECMP_OFS);
	assign sel_mtime    = clint_wr_en && (clint_addr == `CLINT_MTIME_OFS);

	always_ff @(posedge clk) begin
		if (rst) begin
			msip <= 1'b0;
		end else if (sel_msip) begin
			msip <= clint_wdata[0]; // Only bit 0 is implemented
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mtimecmp <= '1; // Keeps mtip low out of reset
		end else if (sel_mtimecmp) begin
			mtimecmp <= clint_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mtime <= '0;
		end else if (sel_mtime) begin
			mtime <= clint_wdata; // Write replaces this cycle's tick
		end else begin
			mtime <= mtime + `XLEN'd1;
		end
	end

	assign mtip = (mtime >= mtimecmp);

	a_known_offset: assert property (@(posedge clk) disable iff (rst)
		clint_wr_en |-> (sel_msip || sel_mtimecmp || sel_mtime));

endmodule

/* logic/csr_addr_decode.sv */
// CSR address decoder giving a register index and a hit flag
`timescale 1ns/1ps
`include "machine_trap_params.svh"

module csr_addr_decode (
	input  logic [11:0]                 csr_addr,
	output machine_trap_pkg::csr_idx_t idx,
	output logic                        hit
);
	import machine_trap_pkg::*;

	always_comb begin
		hit = 1'b1;
		case (csr_addr)
			`CSR_ADDR_MSTATUS:    idx = IDX_MSTATUS;
			`CSR_ADDR_MISA:       idx = IDX_MISA;
			`CSR_ADDR_MEDELEG:    idx = IDX_MEDELEG;
			`CSR_ADDR_MIDELEG:    idx = IDX_MIDELEG;
			`CSR_ADDR_MIE:        idx = IDX_MIE;
			`CSR_ADDR_MTVEC:      idx = IDX_MTVEC;
			`CSR_ADDR_MCOUNTEREN: idx = IDX_MCOUNTEREN;
			`CSR_ADDR_MSTATUSH:   idx = IDX_MSTATUSH;
			`CSR_ADDR_MSCRATCH:   idx = IDX_MSCRATCH;
			`CSR_ADDR_MEPC:       idx = IDX_MEPC;
			`CSR_ADDR_MCAUSE:     idx = IDX_MCAUSE;
			`CSR_ADDR_MTVAL:      idx = IDX_MTVAL;
			`CSR_ADDR_MIP:        idx = IDX_MIP;
			`CSR_ADDR_MTINST:     idx = IDX_MTINST;
			`CSR_ADDR_MTVAL2:     idx = IDX_MTVAL2;
			default: begin
				// Hit stays low so an unknown address never reaches mstatus
				idx = IDX_MSTATUS;
				hit = 1'b0;
			end
		endcase
	end

endmodule

/* logic/csr_file.sv */
// Machine CSR file with read mux, trap entry, mret return and interrupt detect
`timescale 1ns/1ps
`include "machine_trap_params.svh"

module csr_file (
	input  logic                          clk,
	input  logic                          rst,
	input  machine_trap_pkg::trap_kind_t  inst_is,   // One-cycle ebreak, ecall, mret
	input  logic [`XLEN-1:0]              pc,
	input  logic                          rd_en,
	input  logic                          wt_en,
	input  machine_trap_pkg::csr_idx_t    idx,
	input  logic                          hit,
	input  logic [`XLEN-1:0]              source,    // Value computed by the core
	input  logic                          msip,
	input  logic                          mtip,
	output logic [`XLEN-1:0]              csr,
	output logic [`XLEN-1:0]              csr_mtvec,
	output logic [`XLEN-1:0]              csr_mepc,
	output logic                          interrupt
);
	import machine_trap_pkg::*;

	logic [`XLEN-1:0] regs [CSR_COUNT];
	logic [`XLEN-1:0] mstatus;
	logic [`XLEN-1:0] mip_val;
	logic [`XLEN-1:0] rd_val;
	logic [`XLEN-1:0] cause_code;
	logic [`XLEN-1:0] mstatus_trap;
	logic [`XLEN-1:0] mstatus_mret;
	logic             mstatus_mie;
	logic             mstatus_mpie;
	logic             sw_irq;
	logic             exception;
	logic             wr_hit;

	assign mstatus      = regs[IDX_MSTATUS];
	assign mstatus_mie  = |(mstatus & MSTATUS_MIE);
	assign mstatus_mpie = |(mstatus & MSTATUS_MPIE);

	// Stored mip bits plus the live CLINT lines
	assign mip_val = regs[IDX_MIP]
		| (msip ? MIP_MSIP : '0)
		| (mtip ? MIP_MTIP : '0);

	assign sw_irq = |(regs[IDX_MIE] & MIE_MSIE) && |(mip_val & MIP_MSIP);

	assign interrupt = mstatus_mie && |(regs[IDX_MIE] & mip_val);
	assign exception = inst_is.ebreak || inst_is.ecall || interrupt;

	// Synchronous exceptions ahead of interrupts, software ahead of timer
	always_comb begin
		if (inst_is.ebreak) begin
			cause_code = CAUSE_EBREAK;
		end else if (inst_is.ecall) begin
			cause_code = CAUSE_ECALL;
		end else if (sw_irq) begin
			cause_code = CAUSE_MSI;
		end else begin
			cause_code = CAUSE_MTI; // Timer is the only other source
		end
	end

	// MPIE takes MIE, MIE cleared
	assign mstatus_trap = (mstatus & ~(MSTATUS_MIE | MSTATUS_MPIE))
		| (mstatus_mie ? MSTATUS_MPIE : '0);

	// MIE takes MPIE, MPIE set
	assign mstatus_mret = (mstatus & ~MSTATUS_MIE)
		| MSTATUS_MPIE
		| (mstatus_mpie ? MSTATUS_MIE : '0);

	assign wr_hit = wt_en && hit;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < CSR_COUNT; i++) begin
				regs[i] <= '0;
			end
			regs[IDX_MSTATUS] <= `MSTATUS_RESET;
		end else begin
			if (wr_hit) begin
				regs[idx] <= source;
			end
			// Later assignments win over a same-cycle write
			if (exception) begin
				regs[IDX_MSTATUS] <= mstatus_trap;
				regs[IDX_MEPC]    <= pc;
				regs[IDX_MCAUSE]  <= cause_code;
			end else if (inst_is.mret) begin
				regs[IDX_MSTATUS] <= mstatus_mret;
			end
		end
	end

	assign rd_val    = (idx == IDX_MIP) ? mip_val : regs[idx];
	assign csr       = (rd_en && hit) ? rd_val : '0;
	assign csr_mtvec = regs[IDX_MTVEC];
	assign csr_mepc  = regs[IDX_MEPC];

	a_ebreak_ecall_excl: assert property (@(posedge clk) disable iff (rst)
		!(inst_is.ebreak && inst_is.ecall));

	a_mret_alone: assert property (@(posedge clk) disable iff (rst)
		inst_is.mret |-> !(inst_is.ebreak || inst_is.ecall));

	// An accepted interrupt closes MIE at the entry edge
	a_irq_entry: assert property (@(posedge clk) disable iff (rst)
		interrupt |=> !mstatus_mie);

endmodule

/* logic/machine_trap_params.svh */
// Machine trap unit widths, CSR addresses and CLINT register offsets
`ifndef MACHINE_TRAP_PARAMS_SVH
`define MACHINE_TRAP_PARAMS_SVH

`define XLEN 64

// Machine trap setup
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MCOUNTEREN 12'h306
`define CSR_ADDR_MSTATUSH   12'h310
// Machine trap handling
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MTINST     12'h34A
`define CSR_ADDR_MTVAL2     12'h34B

`define MSTATUS_RESET 64'h0000_000A_0000_1800 // SXL and UXL at 2, MPP machine

`define CLINT_MSIP_OFS     16'h0000
`define CLINT_MTIMECMP_OFS 16'h4000
`define CLINT_MTIME_OFS    16'hBFF8

`endif

/* logic/machine_trap_pkg.sv */
// Machine trap package with CSR index, trap kind, bit masks and cause codes
`include "machine_trap_params.svh"

package machine_trap_pkg;

	typedef logic [3:0] csr_idx_t;

	localparam int CSR_COUNT = 15;

	localparam csr_idx_t IDX_MSTATUS    = 4'd0;
	localparam csr_idx_t IDX_MISA       = 4'd1;
	localparam csr_idx_t IDX_MEDELEG    = 4'd2;
	localparam csr_idx_t IDX_MIDELEG    = 4'd3;
	localparam csr_idx_t IDX_MIE        = 4'd4;
	localparam csr_idx_t IDX_MTVEC      = 4'd5;
	localparam csr_idx_t IDX_MCOUNTEREN = 4'd6;
	localparam csr_idx_t IDX_MSTATUSH   = 4'd7;
	localparam csr_idx_t IDX_MSCRATCH   = 4'd8;
	localparam csr_idx_t IDX_MEPC       = 4'd9;
	localparam csr_idx_t IDX_MCAUSE     = 4'd10;
	localparam csr_idx_t IDX_MTVAL      = 4'd11;
	localparam csr_idx_t IDX_MIP        = 4'd12;
	localparam csr_idx_t IDX_MTINST     = 4'd13;
	localparam csr_idx_t IDX_MTVAL2     = 4'd14;

	typedef struct packed {
		logic mret;   // Bit 2
		logic ecall;  // Bit 1
		logic ebreak; // Bit 0
	} trap_kind_t;

	localparam logic [`XLEN-1:0] MSTATUS_MIE  = `XLEN'h8;
	localparam logic [`XLEN-1:0] MSTATUS_MPIE = `XLEN'h80;
	localparam logic [`XLEN-1:0] MIP_MSIP     = `XLEN'h8;
	localparam logic [`XLEN-1:0] MIE_MSIE     = `XLEN'h8;
	localparam logic [`XLEN-1:0] MIP_MTIP     = `XLEN'h80;
	localparam logic [`XLEN-1:0] MIE_MTIE     = `XLEN'h80;

	localparam logic [`XLEN-1:0] CAUSE_EBREAK = `XLEN'd3;
	localparam logic [`XLEN-1:0] CAUSE_ECALL  = `XLEN'd11; // Environment call from M-mode
	localparam logic [`XLEN-1:0] CAUSE_MSI    = {1'b1, 59'd0, 4'd3};
	localparam logic [`XLEN-1:0] CAUSE_MTI    = {1'b1, 59'd0, 4'd7};

endpackage

/* logic/machine_trap_top.sv */
// Machine trap unit top joining the CSR decoder, CSR file and CLINT
`timescale 1ns/1ps
`include "machine_trap_params.svh"

module machine_trap_top (
	input  logic                          clk,
	input  logic                          rst,
	input  machine_trap_pkg::trap_kind_t  inst_is,
	input  logic [`XLEN-1:0]              pc,
	input  logic                          rd_en,
	input  logic                          wt_en,
	input  logic [11:0]                   csr_addr,
	input  logic [`XLEN-1:0]              source,
	input  logic                          clint_wr_en,
	input  logic [15:0]                   clint_addr,
	input  logic [`XLEN-1:0]              clint_wdata,
	output logic [`XLEN-1:0]              csr,
	output logic [`XLEN-1:0]              csr_mtvec,
	output logic [`XLEN-1:0]              csr_mepc,
	output logic                          interrupt,
	output logic [`XLEN-1:0]              mtime
);
	import machine_trap_pkg::*;

	csr_idx_t idx;
	logic     hit;
	logic     msip;
	logic     mtip;

	csr_addr_decode i_csr_addr_decode (
		.csr_addr (csr_addr),
		.idx      (idx),
		.hit      (hit)
	);

	csr_file i_csr_file (
		.clk       (clk),
		.rst       (rst),
		.inst_is   (inst_is),
		.pc        (pc),
		.rd_en     (rd_en),
		.wt_en     (wt_en),
		.idx       (idx),
		.hit       (hit),
		.source    (source),
		.msip      (msip),
		.mtip      (mtip),
		.csr       (csr),
		.csr_mtvec (csr_mtvec),
		.csr_mepc  (csr_mepc),
		.interrupt (interrupt)
	);

	clint i_clint (
		.clk         (clk),
		.rst         (rst),
		.clint_wr_en (clint_wr_en),
		.clint_addr  (clint_addr),
		.clint_wdata (clint_wdata),
		.msip        (msip),
		.mtip        (mtip),
		.mtime       (mtime)
	);

endmodule

/* machine_trap.f */
+incdir+logic
logic/machine_trap_pkg.sv
logic/csr_addr_decode.sv
logic/csr_file.sv
logic/clint.sv
logic/machine_trap_top.sv
tests/machine_trap_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the machine trap testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module machine_trap_tb -f machine_trap.f \
	-o machine_trap_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/machine_trap_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1

/* tests/machine_trap_tb.sv */
// Machine trap unit testbench with a reference model and a compare process
`timescale 1ns/1ps
`include "machine_trap_params.svh"

module machine_trap_tb;
	import machine_trap_pkg::*;

	localparam int CYCLE_LIMIT = 2000; // The six tests need about 150 cycles
	localparam trap_kind_t KIND_NONE   = 3'b000;
	localparam trap_kind_t KIND_EBREAK = 3'b001;
	localparam trap_kind_t KIND_ECALL  = 3'b010;
	localparam trap_kind_t KIND_MRET   = 3'b100;
	localparam logic [11:0] CSR_ADDRS [15] = '{
		`CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MEDELEG, `CSR_ADDR_MIDELEG,
		`CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MCOUNTEREN, `CSR_ADDR_MSTATUSH,
		`CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL,
		`CSR_ADDR_MIP, `CSR_ADDR_MTINST, `CSR_ADDR_MTVAL2};

	logic             clk, rst, rd_en, wt_en, clint_wr_en, interrupt;
	trap_kind_t       inst_is;
	logic [11:0]      csr_addr;
	logic [15:0]      clint_addr;
	logic [`XLEN-1:0] pc, source, clint_wdata, csr, csr_mtvec, csr_mepc, mtime;

	// Reference model state
	logic [`XLEN-1:0] m_regs [15];
	logic             m_msip;
	logic [`XLEN-1:0] m_mtimecmp, m_mtime;
	int error_count = 0;
	int test_errors = 0;
	int test_num = 0;
	int tests_passed = 0;
	int cycle_count = 0;

	machine_trap_top i_machine_trap_top (.*);

	function automatic logic find_index(input logic [11:0] addr, output logic [3:0] idx);
		find_index = 1'b0;
		idx = '0;
		for (int i = 0; i < 15; i++) begin
			if (CSR_ADDRS[4'(i)] == addr) begin
				find_index = 1'b1;
				idx = 4'(i);
			end
		end
	endfunction

	function automatic logic [`XLEN-1:0] ref_mip();
		return m_regs[IDX_MIP] | (m_msip ? MIP_MSIP : '0)
			| ((m_mtime >= m_mtimecmp) ? MIP_MTIP : '0);
	endfunction

	function automatic logic ref_interrupt();
		return m_regs[IDX_MSTATUS][3] && ((m_regs[IDX_MIE] & ref_mip()) != '0);
	endfunction

	function automatic logic [`XLEN-1:0] ref_cause(input trap_kind_t kind);
		if (kind.ebreak)
			return CAUSE_EBREAK;
		if (kind.ecall)
			return CAUSE_ECALL;
		if ((m_regs[IDX_MIE] & ref_mip() & MIE_MSIE) != '0)
			return CAUSE_MSI;
		return CAUSE_MTI;
	endfunction

	function automatic logic [`XLEN-1:0] ref_mstatus(input logic [`XLEN-1:0] old, input logic mret);
		logic [`XLEN-1:0] next;
		next = old;
		if (mret) begin
			next[3] = old[7]; // MIE back from MPIE
			next[7] = 1'b1;
		end else begin
			next[7] = old[3]; // Trap entry saves MIE
			next[3] = 1'b0;
		end
		return next;
	endfunction

	function automatic logic [`XLEN-1:0] ref_read(input logic [11:0] addr, input logic rd);
		logic [3:0] idx;
		logic       known;
		known = find_index(addr, idx);
		if (!rd || !known)
			return '0;
		return (idx == IDX_MIP) ? ref_mip() : m_regs[idx];
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		logic [3:0] widx;
		logic       whit;
		logic       trap;
		whit = find_index(csr_addr, widx);
		trap = inst_is.ebreak || inst_is.ecall || ref_interrupt();
		if (rst) begin
			for (int i = 0; i < 15; i++)
				m_regs[4'(i)] <= '0;
			m_regs[IDX_MSTATUS] <= `MSTATUS_RESET;
			m_msip <= 1'b0;
			m_mtimecmp <= '1;
			m_mtime <= '0;
		end else begin
			if (wt_en && whit)
				m_regs[widx] <= source;
			if (trap) begin
				m_regs[IDX_MSTATUS] <= ref_mstatus(m_regs[IDX_MSTATUS], 1'b0);
				m_regs[IDX_MEPC] <= pc;
				m_regs[IDX_MCAUSE] <= ref_cause(inst_is);
			end else if (inst_is.mret) begin
				m_regs[IDX_MSTATUS] <= ref_mstatus(m_regs[IDX_MSTATUS], 1'b1);
			end
			if (clint_wr_en && clint_addr == `CLINT_MSIP_OFS)
				m_msip <= clint_wdata[0];
			if (clint_wr_en && clint_addr == `CLINT_MTIMECMP_OFS)
				m_mtimecmp <= clint_wdata;
			m_mtime <= (clint_wr_en && clint_addr == `CLINT_MTIME_OFS) ? clint_wdata : m_mtime + 1;
		end
	end

	// Every output against the model, away from the driving edge
	always @(negedge clk) begin
		if (!rst) begin
			check_value(csr, ref_read(csr_addr, rd_en), "csr read port");
			check_value(64'(interrupt), 64'(ref_interrupt()), "interrupt line");
			check_value(mtime, m_mtime, "mtime");
			check_value(csr_mepc, m_regs[IDX_MEPC], "csr_mepc");
			check_value(csr_mtvec, m_regs[IDX_MTVEC], "csr_mtvec");
		end
	end

	task automatic check_value(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
			input string msg);
		if (got !== exp) begin
			error_count++;
			test_errors++;
			$display("mismatch at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (test_errors == 0)
			tests_passed++;
		$display("test %0d %s: %s", test_num, name, (test_errors == 0) ? "ok" : "errors");
		test_errors = 0;
	endtask

	task automatic clear_strobes();
		wt_en <= 1'b0;
		rd_en <= 1'b0;
		inst_is <= KIND_NONE;
		clint_wr_en <= 1'b0;
	endtask

	task automatic csr_write(input logic [11:0] addr, input logic [`XLEN-1:0] value);
		@(posedge clk);
		clear_strobes();
		wt_en <= 1'b1;
		csr_addr <= addr;
		source <= value;
	endtask

	task automatic csr_read(input logic [11:0] addr, output logic [`XLEN-1:0] value);
		@(posedge clk);
		clear_strobes();
		rd_en <= 1'b1;
		csr_addr <= addr;
		@(negedge clk);
		value = csr;
	endtask

	task automatic trap_pulse(input trap_kind_t kind, input logic [`XLEN-1:0] pc_val);
		@(posedge clk);
		clear_strobes();
		inst_is <= kind;
		pc <= pc_val;
	endtask

	task automatic clint_write(input logic [15:0] addr, input logic [`XLEN-1:0] data);
		@(posedge clk);
		clear_strobes();
		clint_wr_en <= 1'b1;
		clint_addr <= addr;
		clint_wdata <= data;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			clear_strobes();
		end
	endtask

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [`XLEN-1:0] got, pc_val, target;
		logic [`XLEN-1:0] wr_vals [15];
		int waited;
		void'($urandom(10295));
		rst = 1'b1;
		inst_is = KIND_NONE;
		pc = '0;
		rd_en = 1'b0;
		wt_en = 1'b0;
		csr_addr = '0;
		source = '0;
		clint_wr_en = 1'b0;
		clint_addr = `CLINT_MSIP_OFS;
		clint_wdata = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < 15; i++) begin
			csr_read(CSR_ADDRS[4'(i)], got);
			check_value(got, (i == 0) ? `MSTATUS_RESET : 64'd0, "reset value");
		end
		check_value(64'(interrupt), 64'd0, "interrupt after reset");
		end_test("reset values");

		for (int i = 0; i < 15; i++) begin
			wr_vals[4'(i)] = {$urandom, $urandom};
			if (i == 0)
				wr_vals[0] = wr_vals[0] & ~MSTATUS_MIE; // No trap during readback
			csr_write(CSR_ADDRS[4'(i)], wr_vals[4'(i)]);
			csr_read(CSR_ADDRS[4'(i)], got);
			check_value(got, wr_vals[4'(i)], "readback after write");
		end
		csr_write(12'h7C0, {$urandom, $urandom}); // Not a machine trap CSR
		csr_read(12'h7C0, got);
		check_value(got, 64'd0, "unknown address read");
		for (int i = 0; i < 15; i++) begin
			csr_read(CSR_ADDRS[4'(i)], got);
			check_value(got, wr_vals[4'(i)], "CSR after unknown write");
		end
		csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET);
		csr_write(`CSR_ADDR_MIE, '0);
		csr_write(`CSR_ADDR_MIP, '0);
		end_test("writes and reads");

		for (int k = 0; k < 2; k++) begin
			pc_val = {$urandom, $urandom};
			csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET | MSTATUS_MIE);
			trap_pulse((k == 0) ? KIND_EBREAK : KIND_ECALL, pc_val);
			csr_read(`CSR_ADDR_MEPC, got);
			check_value(got, pc_val, "mepc after trap");
			check_value(csr_mepc, pc_val, "csr_mepc after trap");
			csr_read(`CSR_ADDR_MCAUSE, got);
			check_value(got, (k == 0) ? 64'd3 : 64'd11, "mcause after trap");
			csr_read(`CSR_ADDR_MSTATUS, got);
			check_value(got, `MSTATUS_RESET | MSTATUS_MPIE, "mstatus after trap");
		end
		end_test("ebreak and ecall entry");

		trap_pulse(KIND_MRET, pc_val);
		csr_read(`CSR_ADDR_MSTATUS, got);
		check_value(got, `MSTATUS_RESET | MSTATUS_MIE | MSTATUS_MPIE, "mstatus after mret");
		csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET);
		trap_pulse(KIND_MRET, pc_val);
		csr_read(`CSR_ADDR_MSTATUS, got);
		check_value(got, `MSTATUS_RESET | MSTATUS_MPIE, "mret with MPIE clear");
		end_test("mret");

		clint_write(`CLINT_MSIP_OFS, 64'd1);
		csr_write(`CSR_ADDR_MIE, MIE_MSIE);
		csr_read(`CSR_ADDR_MIP, got);
		check_value(got, MIP_MSIP, "mip software bit");
		repeat (3) begin
			@(negedge clk);
			check_value(64'(interrupt), 64'd0, "interrupt with MIE clear");
		end
		pc_val = {$urandom, $urandom};
		@(posedge clk);
		pc <= pc_val;
		csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET | MSTATUS_MIE);
		idle(1);
		@(negedge clk);
		check_value(64'(interrupt), 64'd1, "software interrupt rise");
		@(negedge clk);
		check_value(64'(interrupt), 64'd0, "interrupt after entry");
		check_value(csr_mepc, pc_val, "mepc at software interrupt");
		csr_read(`CSR_ADDR_MCAUSE, got);
		check_value(got, CAUSE_MSI, "mcause software interrupt");
		clint_write(`CLINT_MSIP_OFS, 64'd0);
		end_test("software interrupt");

		csr_write(`CSR_ADDR_MIE, MIE_MTIE);
		target = m_mtime + 64'($urandom_range(40, 5));
		clint_write(`CLINT_MTIMECMP_OFS, target);
		pc_val = {$urandom, $urandom};
		csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET | MSTATUS_MIE);
		pc <= pc_val;
		csr_read(`CSR_ADDR_MIP, got); // rd_en stays on mip while waiting
		waited = 0;
		while (interrupt !== 1'b1 && waited < 64) begin
			@(negedge clk);
			waited++;
		end
		if (waited >= 64) begin
			error_count++;
			test_errors++;
			$display("timer interrupt did not rise within 64 cycles of setting MIE");
		end else begin
			check_value(mtime, target, "mtime at timer interrupt");
			check_value(csr & MIP_MTIP, MIP_MTIP, "mip timer bit");
			@(negedge clk);
			check_value(csr_mepc, pc_val, "mepc at timer interrupt");
			csr_read(`CSR_ADDR_MCAUSE, got);
			check_value(got, CAUSE_MTI, "mcause timer interrupt");
		end
		// Timer still pending, software wins by priority
		csr_write(`CSR_ADDR_MIE, MIE_MSIE | MIE_MTIE);
		clint_write(`CLINT_MSIP_OFS, 64'd1);
		csr_write(`CSR_ADDR_MSTATUS, `MSTATUS_RESET | MSTATUS_MIE);
		idle(1);
		csr_read(`CSR_ADDR_MCAUSE, got);
		check_value(got, CAUSE_MSI, "mcause with both pending");
		clint_write(`CLINT_MSIP_OFS, 64'd0);
		idle(2);
		end_test("timer interrupt");

		$display("tests run %0d, passed %0d, failed checks %0d",
			test_num, tests_passed, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
